/* exec_shadow.sv */
`default_nettype none

module exec_shadow import issue_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      hold,
  input  logic      redirect,
  input  op_t       iss0_op,
  input  op_t       iss1_op,
  input  reg_addr_t iss0_waddr,
  input  reg_addr_t iss1_waddr,
  output op_t       e0_op,
  output op_t       e1_op,
  output reg_addr_t e0_waddr,
  output reg_addr_t e1_waddr,
  output op_t       m0_op,
  output op_t       m1_op
);

  always_ff @(posedge clock) begin
    if (!reset) begin
      e0_op <= '0;
      e1_op <= '0;
      m0_op <= '0;
      m1_op <= '0;
    end else begin
      if (!hold) begin
        e0_op <= iss0_op;
        e1_op <= iss1_op;
        m0_op <= e0_op;
        m1_op <= e1_op;
      end
      if (redirect) begin
        e0_op <= '0; // younger than the redirect.
        e1_op <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      e0_waddr <= iss0_waddr;
      e1_waddr <= iss1_waddr;
    end
  end

endmodule

`default_nettype wire

/* flist.f */
issue_pkg.sv
pairing_buffer.sv
issue_stage.sv
int_regfile.sv
exec_shadow.sv
issue_top.sv
tb_issue_top.sv

/* int_regfile.sv */
`default_nettype none

module int_regfile import issue_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            rd0_en1, rd0_en2, rd1_en1, rd1_en2,
  input  reg_addr_t       rd0_addr1, rd0_addr2, rd1_addr1, rd1_addr2,
  input  logic            wb0_en,
  input  reg_addr_t       wb0_addr,
  input  logic [XLEN-1:0] wb0_data,
  input  logic            wb1_en,
  input  reg_addr_t       wb1_addr,
  input  logic [XLEN-1:0] wb1_data,
  input  logic            hold,
  output logic [XLEN-1:0] iss0_rdata1,
  output logic [XLEN-1:0] iss0_rdata2,
  output logic [XLEN-1:0] iss1_rdata1,
  output logic [XLEN-1:0] iss1_rdata2
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (wb0_en) begin
      regs[wb0_addr] <= wb0_data;
    end
    if (wb1_en) begin
      regs[wb1_addr] <= wb1_data; // wb1 wins.
    end
  end

  // reads see the value before this edge's writes.
  always_ff @(posedge clock) begin
    if (!hold) begin
      iss0_rdata1 <= (rd0_en1 && rd0_addr1 != '0) ? regs[rd0_addr1] : '0;
      iss0_rdata2 <= (rd0_en2 && rd0_addr2 != '0) ? regs[rd0_addr2] : '0;
      iss1_rdata1 <= (rd1_en1 && rd1_addr1 != '0) ? regs[rd1_addr1] : '0;
      iss1_rdata2 <= (rd1_en2 && rd1_addr2 != '0) ? regs[rd1_addr2] : '0;
    end
  end

  // writeback never targets x0.
  a_no_x0_write: assert property (@(posedge clock) disable iff (!reset)
    !(wb0_en && wb0_addr == '0) && !(wb1_en && wb1_addr == '0));

endmodule

`default_nettype wire

/* issue_pkg.sv */
`default_nettype none

package issue_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  rm_t;
  typedef logic [1:0]  fs_t;
  typedef logic [14:0] op_t;

  localparam int OP_RDEN1  = 0;
  localparam int OP_RDEN2  = 1;
  localparam int OP_WREN   = 2;
  localparam int OP_LOAD   = 3;
  localparam int OP_STORE  = 4;
  localparam int OP_CRDEN  = 5;
  localparam int OP_CWREN  = 6;
  localparam int OP_FWREN  = 7;
  localparam int OP_FRDEN1 = 8;
  localparam int OP_FRDEN2 = 9;
  localparam int OP_FRDEN3 = 10;
  localparam int OP_FLOAD  = 11;
  localparam int OP_FSTORE = 12;
  localparam int OP_FPU    = 13;
  localparam int OP_FPUF   = 14;

  localparam op_t OP_FP_MASK = 15'h7f80; // bits 7 and up.

  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FCSR   = 12'h003;
  localparam rm_t       RM_DYN     = 3'b111;
  localparam fs_t       FS_OFF     = 2'b00;

  typedef enum logic [1:0] {
    EMPTY,
    ONE,
    TWO
  } issue_state_t;

  function automatic logic op_mem(op_t op);
    return op[OP_LOAD] | op[OP_STORE] | op[OP_FLOAD] | op[OP_FSTORE];
  endfunction

  function automatic logic op_csr(op_t op);
    return op[OP_CRDEN] | op[OP_CWREN];
  endfunction

  function automatic logic flag_csr(csr_addr_t addr);
    return addr == CSR_FFLAGS || addr == CSR_FCSR;
  endfunction

endpackage

`default_nettype wire

/* issue_stage.sv */
`default_nettype none

module issue_stage import issue_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            hold,
  input  logic            redirect,
  input  fs_t             fs,
  input  rm_t             frm,
  input  op_t             pb0_op, pb1_op,
  input  reg_addr_t       pb0_raddr1, pb0_raddr2, pb0_raddr3, pb0_waddr,
  input  reg_addr_t       pb1_raddr1, pb1_raddr2, pb1_raddr3, pb1_waddr,
  input  csr_addr_t       pb0_caddr, pb1_caddr,
  input  rm_t             pb0_rm, pb1_rm,
  input  op_t             e0_op, e1_op, m0_op, m1_op,
  input  reg_addr_t       e0_waddr, e1_waddr,
  input  logic [XLEN-1:0] csr_cdata,
  input  logic [XLEN-1:0] fp_csr_cdata,
  input  logic            fp_csr_ready,
  output logic            advance,
  output logic            flush,
  output logic            rd0_en1, rd0_en2, rd1_en1, rd1_en2,
  output reg_addr_t       rd0_addr1, rd0_addr2, rd1_addr1, rd1_addr2,
  output logic            frden1, frden2, frden3,
  output reg_addr_t       fraddr1, fraddr2, fraddr3,
  output logic            crden,
  output csr_addr_t       craddr,
  output op_t             iss0_op, iss1_op,
  output reg_addr_t       iss0_raddr1, iss0_raddr2, iss0_raddr3, iss0_waddr,
  output reg_addr_t       iss1_raddr1, iss1_raddr2, iss1_raddr3, iss1_waddr,
  output csr_addr_t       iss0_caddr, iss1_caddr,
  output rm_t             iss0_rm, iss1_rm,
  output logic [XLEN-1:0] iss0_cdata, iss1_cdata
);

  op_t  op0, op1;
  rm_t  rm0, rm1;
  logic cw_busy, ff_busy, flag_rd, load_use, stall;

  // load in src writes a register that op reads.
  function automatic logic hit(op_t src, reg_addr_t wa, op_t op,
                               reg_addr_t a1, reg_addr_t a2, reg_addr_t a3);
    return (src[OP_LOAD] && ((op[OP_RDEN1] && a1 == wa) || (op[OP_RDEN2] && a2 == wa))) ||
           (src[OP_FLOAD] && ((op[OP_FRDEN1] && a1 == wa) || (op[OP_FRDEN2] && a2 == wa) ||
                              (op[OP_FRDEN3] && a3 == wa)));
  endfunction

  always_comb begin
    op0 = pb0_op;
    op1 = pb1_op;
    rm0 = pb0_rm;
    rm1 = pb1_rm;
    if (fs == FS_OFF) begin
      op0 = op0 & ~OP_FP_MASK; // fp ops become no-ops.
      op1 = op1 & ~OP_FP_MASK;
      rm0 = '0;
      rm1 = '0;
    end
    if (rm0 == RM_DYN) begin
      rm0 = frm;
    end
    if (rm1 == RM_DYN) begin
      rm1 = frm;
    end
  end

  assign rd0_en1   = op0[OP_RDEN1];
  assign rd0_en2   = op0[OP_RDEN2];
  assign rd0_addr1 = pb0_raddr1;
  assign rd0_addr2 = pb0_raddr2;
  assign rd1_en1   = op1[OP_RDEN1];
  assign rd1_en2   = op1[OP_RDEN2];
  assign rd1_addr1 = pb1_raddr1;
  assign rd1_addr2 = pb1_raddr2;

  // one fp read port, slot0 first.
  assign frden1  = op0[OP_FRDEN1] | op1[OP_FRDEN1];
  assign frden2  = op0[OP_FRDEN2] | op1[OP_FRDEN2];
  assign frden3  = op0[OP_FRDEN3] | op1[OP_FRDEN3];
  assign fraddr1 = op0[OP_FRDEN1] ? pb0_raddr1 : pb1_raddr1;
  assign fraddr2 = op0[OP_FRDEN2] ? pb0_raddr2 : pb1_raddr2;
  assign fraddr3 = op0[OP_FRDEN3] ? pb0_raddr3 : pb1_raddr3;
  assign crden   = op0[OP_CRDEN] | op1[OP_CRDEN];
  assign craddr  = op0[OP_CRDEN] ? pb0_caddr : pb1_caddr;

  // iss is the pair entering execute, e and m follow it.
  assign cw_busy = iss0_op[OP_CWREN] | iss1_op[OP_CWREN] | e0_op[OP_CWREN] |
                   e1_op[OP_CWREN] | m0_op[OP_CWREN] | m1_op[OP_CWREN];
  assign ff_busy = iss0_op[OP_FPUF] | iss1_op[OP_FPUF] | e0_op[OP_FPUF] |
                   e1_op[OP_FPUF] | m0_op[OP_FPUF] | m1_op[OP_FPUF];
  assign flag_rd = (op0[OP_CRDEN] && flag_csr(pb0_caddr)) ||
                   (op1[OP_CRDEN] && flag_csr(pb1_caddr));

  assign load_use = hit(iss0_op, iss0_waddr, op0, pb0_raddr1, pb0_raddr2, pb0_raddr3) ||
                    hit(iss1_op, iss1_waddr, op0, pb0_raddr1, pb0_raddr2, pb0_raddr3) ||
                    hit(e0_op, e0_waddr, op0, pb0_raddr1, pb0_raddr2, pb0_raddr3) ||
                    hit(e1_op, e1_waddr, op0, pb0_raddr1, pb0_raddr2, pb0_raddr3) ||
                    hit(iss0_op, iss0_waddr, op1, pb1_raddr1, pb1_raddr2, pb1_raddr3) ||
                    hit(iss1_op, iss1_waddr, op1, pb1_raddr1, pb1_raddr2, pb1_raddr3) ||
                    hit(e0_op, e0_waddr, op1, pb1_raddr1, pb1_raddr2, pb1_raddr3) ||
                    hit(e1_op, e1_waddr, op1, pb1_raddr1, pb1_raddr2, pb1_raddr3);

  assign stall   = cw_busy || (flag_rd && ff_busy) || load_use;
  assign advance = !stall && !hold;
  assign flush   = redirect;

  always_ff @(posedge clock) begin
    if (!reset) begin
      iss0_op <= '0;
      iss1_op <= '0;
    end else if (redirect) begin
      iss0_op <= '0;
      iss1_op <= '0;
    end else if (!hold) begin
      iss0_op <= stall ? '0 : op0; // bubble on stall.
      iss1_op <= stall ? '0 : op1;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      iss0_raddr1 <= pb0_raddr1;
      iss0_raddr2 <= pb0_raddr2;
      iss0_raddr3 <= pb0_raddr3;
      iss0_waddr  <= pb0_waddr;
      iss0_caddr  <= pb0_caddr;
      iss0_rm     <= rm0;
      iss1_raddr1 <= pb1_raddr1;
      iss1_raddr2 <= pb1_raddr2;
      iss1_raddr3 <= pb1_raddr3;
      iss1_waddr  <= pb1_waddr;
      iss1_caddr  <= pb1_caddr;
      iss1_rm     <= rm1;
      iss0_cdata  <= fp_csr_ready ? fp_csr_cdata : csr_cdata; // shared csr port.
      iss1_cdata  <= fp_csr_ready ? fp_csr_cdata : csr_cdata;
    end
  end

endmodule

`default_nettype wire

/* issue_top.sv */
`default_nettype none

module issue_top import issue_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            dec_valid,
  input  op_t             dec0_op, dec1_op,
  input  reg_addr_t       dec0_raddr1, dec0_raddr2, dec0_raddr3, dec0_waddr,
  input  reg_addr_t       dec1_raddr1, dec1_raddr2, dec1_raddr3, dec1_waddr,
  input  csr_addr_t       dec0_caddr, dec1_caddr,
  input  rm_t             dec0_rm, dec1_rm,
  output logic            halt,
  input  logic            hold,
  input  logic            redirect,
  input  fs_t             fs,
  input  rm_t             frm,
  output logic            crden,
  output csr_addr_t       craddr,
  input  logic [XLEN-1:0] csr_cdata,
  input  logic [XLEN-1:0] fp_csr_cdata,
  input  logic            fp_csr_ready,
  output logic            frden1, frden2, frden3,
  output reg_addr_t       fraddr1, fraddr2, fraddr3,
  input  logic            wb0_en, wb1_en,
  input  reg_addr_t       wb0_addr, wb1_addr,
  input  logic [XLEN-1:0] wb0_data, wb1_data,
  output op_t             iss0_op, iss1_op,
  output reg_addr_t       iss0_raddr1, iss0_raddr2, iss0_raddr3, iss0_waddr,
  output reg_addr_t       iss1_raddr1, iss1_raddr2, iss1_raddr3, iss1_waddr,
  output csr_addr_t       iss0_caddr, iss1_caddr,
  output rm_t             iss0_rm, iss1_rm,
  output logic [XLEN-1:0] iss0_rdata1, iss0_rdata2, iss1_rdata1, iss1_rdata2,
  output logic [XLEN-1:0] iss0_cdata, iss1_cdata
);

  logic      advance, flush;

  op_t       pb0_op, pb1_op;
  reg_addr_t pb0_raddr1, pb0_raddr2, pb0_raddr3, pb0_waddr;
  reg_addr_t pb1_raddr1, pb1_raddr2, pb1_raddr3, pb1_waddr;
  csr_addr_t pb0_caddr, pb1_caddr;
  rm_t       pb0_rm, pb1_rm;

  logic      rd0_en1, rd0_en2, rd1_en1, rd1_en2;
  reg_addr_t rd0_addr1, rd0_addr2, rd1_addr1, rd1_addr2;

  op_t       e0_op, e1_op, m0_op, m1_op;
  reg_addr_t e0_waddr, e1_waddr;

  // port names line up across the four blocks.
  pairing_buffer buf_i (.*);

  issue_stage #(
    .XLEN(XLEN)
  ) stage_i (.*);

  int_regfile #(
    .XLEN(XLEN)
  ) rf_i (.*);

  exec_shadow shadow_i (.*);

endmodule

`default_nettype wire

/* pairing_buffer.sv */
`default_nettype none

module pairing_buffer import issue_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dec_valid,
  input  op_t       dec0_op, dec1_op,
  input  reg_addr_t dec0_raddr1, dec0_raddr2, dec0_raddr3, dec0_waddr,
  input  reg_addr_t dec1_raddr1, dec1_raddr2, dec1_raddr3, dec1_waddr,
  input  csr_addr_t dec0_caddr, dec1_caddr,
  input  rm_t       dec0_rm, dec1_rm,
  input  logic      advance,
  input  logic      flush,
  output op_t       pb0_op, pb1_op,
  output reg_addr_t pb0_raddr1, pb0_raddr2, pb0_raddr3, pb0_waddr,
  output reg_addr_t pb1_raddr1, pb1_raddr2, pb1_raddr3, pb1_waddr,
  output csr_addr_t pb0_caddr, pb1_caddr,
  output rm_t       pb0_rm, pb1_rm,
  output logic      halt
);

  issue_state_t state;

  op_t       s0_op, s1_op;
  reg_addr_t s0_raddr1, s0_raddr2, s0_raddr3, s0_waddr;
  reg_addr_t s1_raddr1, s1_raddr2, s1_raddr3, s1_waddr;
  csr_addr_t s0_caddr, s1_caddr;
  rm_t       s0_rm, s1_rm;

  logic s0_writes, rd_hit, pairs, drain, load;

  always_comb begin
    s0_writes = (s0_op[OP_WREN] && s0_waddr != '0) || s0_op[OP_FWREN];
    rd_hit = s0_writes &&
             (((s1_op[OP_RDEN1] || s1_op[OP_FRDEN1]) && s1_raddr1 == s0_waddr) ||
              ((s1_op[OP_RDEN2] || s1_op[OP_FRDEN2]) && s1_raddr2 == s0_waddr) ||
              (s1_op[OP_FRDEN3] && s1_raddr3 == s0_waddr)); // int and fp alike.
    pairs = !(rd_hit || (op_mem(s0_op) && op_mem(s1_op)) ||
              (op_csr(s0_op) && op_csr(s1_op)) || s0_op[OP_CWREN]);
  end

  assign drain = state == ONE || (state == TWO && pairs); // empties on advance.
  assign halt  = state != EMPTY && !flush && !(advance && drain);
  assign load  = dec_valid && !halt;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= EMPTY;
    end else if (flush) begin
      state <= EMPTY; // pair arriving with a redirect is dropped.
    end else if (load) begin
      state <= (dec1_op == '0) ? ONE : TWO;
    end else if (advance) begin
      state <= (state == TWO && !pairs) ? ONE : EMPTY;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      s0_op     <= dec0_op;
      s0_raddr1 <= dec0_raddr1;
      s0_raddr2 <= dec0_raddr2;
      s0_raddr3 <= dec0_raddr3;
      s0_waddr  <= dec0_waddr;
      s0_caddr  <= dec0_caddr;
      s0_rm     <= dec0_rm;
      s1_op     <= dec1_op;
      s1_raddr1 <= dec1_raddr1;
      s1_raddr2 <= dec1_raddr2;
      s1_raddr3 <= dec1_raddr3;
      s1_waddr  <= dec1_waddr;
      s1_caddr  <= dec1_caddr;
      s1_rm     <= dec1_rm;
    end else if (advance && state == TWO && !pairs) begin
      s0_op     <= s1_op; // unpaired slot1 moves up.
      s0_raddr1 <= s1_raddr1;
      s0_raddr2 <= s1_raddr2;
      s0_raddr3 <= s1_raddr3;
      s0_waddr  <= s1_waddr;
      s0_caddr  <= s1_caddr;
      s0_rm     <= s1_rm;
    end
  end

  assign pb0_op     = (state == EMPTY) ? '0 : s0_op;
  assign pb1_op     = (state == TWO && pairs) ? s1_op : '0;
  assign pb0_raddr1 = s0_raddr1;
  assign pb0_raddr2 = s0_raddr2;
  assign pb0_raddr3 = s0_raddr3;
  assign pb0_waddr  = s0_waddr;
  assign pb0_caddr  = s0_caddr;
  assign pb0_rm     = s0_rm;
  assign pb1_raddr1 = s1_raddr1;
  assign pb1_raddr2 = s1_raddr2;
  assign pb1_raddr3 = s1_raddr3;
  assign pb1_waddr  = s1_waddr;
  assign pb1_caddr  = s1_caddr;
  assign pb1_rm     = s1_rm;

  // decode holds its pair while halted.
  a_dec_hold: assert property (@(posedge clock) disable iff (!reset)
    dec_valid && halt && !flush |=> dec_valid &&
      $stable({dec0_op, dec1_op, dec0_waddr, dec1_waddr, dec0_caddr, dec1_caddr}) &&
      $stable({dec0_rm, dec1_rm}) &&
      $stable({dec0_raddr1, dec0_raddr2, dec0_raddr3, dec1_raddr1, dec1_raddr2, dec1_raddr3}));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_issue_top -f flist.f
./obj_dir/Vtb_issue_top > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* tb_issue_top.sv */
`default_nettype none

module tb_issue_top import issue_pkg::*; ();

  localparam int XLEN = 32;
  localparam int NPAIRS = 2000;
  localparam int RESET_CYCLES = 16;
  localparam int LIMIT = RESET_CYCLES + NPAIRS * 6;

  typedef struct packed {
    op_t       op;
    reg_addr_t r1, r2, r3, wa;
    csr_addr_t ca;
    rm_t       rm;
  } instr_t;

  logic            clock, reset, dec_valid, hold, redirect, fp_csr_ready;
  op_t             dec0_op, dec1_op;
  reg_addr_t       dec0_raddr1, dec0_raddr2, dec0_raddr3, dec0_waddr;
  reg_addr_t       dec1_raddr1, dec1_raddr2, dec1_raddr3, dec1_waddr;
  csr_addr_t       dec0_caddr, dec1_caddr;
  rm_t             dec0_rm, dec1_rm, frm;
  fs_t             fs;
  logic [XLEN-1:0] csr_cdata, fp_csr_cdata, wb0_data, wb1_data;
  logic            wb0_en, wb1_en;
  reg_addr_t       wb0_addr, wb1_addr;
  logic            halt, crden, frden1, frden2, frden3;
  csr_addr_t       craddr;
  reg_addr_t       fraddr1, fraddr2, fraddr3;
  op_t             iss0_op, iss1_op;
  reg_addr_t       iss0_raddr1, iss0_raddr2, iss0_raddr3, iss0_waddr;
  reg_addr_t       iss1_raddr1, iss1_raddr2, iss1_raddr3, iss1_waddr;
  csr_addr_t       iss0_caddr, iss1_caddr;
  rm_t             iss0_rm, iss1_rm;
  logic [XLEN-1:0] iss0_rdata1, iss0_rdata2, iss1_rdata1, iss1_rdata2;
  logic [XLEN-1:0] iss0_cdata, iss1_cdata;

  issue_top #(.XLEN(XLEN)) dut_i (.*);

  instr_t          q[$];
  instr_t          pend0, pend1, g0, g1;
  logic [XLEN-1:0] regs_model [32];
  op_t             h_op [2][2]; // [age][slot] of issued pairs.
  reg_addr_t       h_wa [2][2];
  logic            pending, acc, v0, v1;
  logic            req_crden;
  logic [2:0]      req_frden;
  csr_addr_t       req_craddr;
  reg_addr_t       req_fraddr [3];
  int              sent, cycles;
  int              checks [6];
  int              errors [6];
  string           names [6] = '{"order", "pairing", "hazard", "fp gating",
                                 "operand data", "read requests"};

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: the DUT stopped issuing before all pairs drained");
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_op(int t, op_t exp, op_t act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_addr(int t, reg_addr_t exp, reg_addr_t act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_caddr(int t, csr_addr_t exp, csr_addr_t act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_rm(int t, rm_t exp, rm_t act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic check_flag(int t, logic exp, logic act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %b actual %b", names[t], exp, act);
    end
  endtask

  task automatic check_data(int t, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("Error %s: expected %h actual %h", names[t], exp, act);
    end
  endtask

  task automatic report_fault(int t, string msg);
    errors[t]++;
    $display("%s: %s", names[t], msg);
  endtask

  function automatic instr_t random_instr();
    instr_t i;
    csr_addr_t csrs [4] = '{12'h001, 12'h003, 12'h300, 12'hc00};
    i.op = op_t'($urandom & $urandom);
    if (i.op[6:0] == '0) begin
      i.op[OP_RDEN1] = 1'b1; // every op keeps an integer part.
    end
    i.r1 = reg_addr_t'($urandom % 8);
    i.r2 = reg_addr_t'($urandom % 8);
    i.r3 = reg_addr_t'($urandom % 8);
    i.wa = reg_addr_t'($urandom % 8);
    i.ca = csrs[$urandom % 4];
    i.rm = rm_t'($urandom);
    return i;
  endfunction

  function automatic logic is_mem(op_t op);
    return op[OP_LOAD] || op[OP_STORE] || op[OP_FLOAD] || op[OP_FSTORE];
  endfunction

  function automatic logic pair_ok(instr_t a, instr_t b);
    logic wr, dep;
    wr = (a.op[OP_WREN] && a.wa != 0) || a.op[OP_FWREN];
    dep = wr && (((b.op[OP_RDEN1] || b.op[OP_FRDEN1]) && b.r1 == a.wa) ||
                 ((b.op[OP_RDEN2] || b.op[OP_FRDEN2]) && b.r2 == a.wa) ||
                 (b.op[OP_FRDEN3] && b.r3 == a.wa));
    return !(dep || (is_mem(a.op) && is_mem(b.op)) || a.op[OP_CWREN] ||
             ((a.op[OP_CRDEN] || a.op[OP_CWREN]) && (b.op[OP_CRDEN] || b.op[OP_CWREN])));
  endfunction

  // load in the last issue cycle feeding a read.
  function automatic logic uses_load(op_t src, reg_addr_t wa, op_t op,
                                     reg_addr_t r1, reg_addr_t r2, reg_addr_t r3);
    logic int_hit, fp_hit;
    int_hit = (op[OP_RDEN1] && r1 == wa) || (op[OP_RDEN2] && r2 == wa);
    fp_hit = (op[OP_FRDEN1] && r1 == wa) || (op[OP_FRDEN2] && r2 == wa) ||
             (op[OP_FRDEN3] && r3 == wa);
    return (src[OP_LOAD] && int_hit) || (src[OP_FLOAD] && fp_hit);
  endfunction

  function automatic logic [XLEN-1:0] rf_read(reg_addr_t a);
    return (a == 0) ? '0 : regs_model[a];
  endfunction

  task automatic check_slot(op_t op, reg_addr_t r1, reg_addr_t r2, reg_addr_t r3,
                            reg_addr_t wa, csr_addr_t ca, rm_t rm, logic [XLEN-1:0] d1,
                            logic [XLEN-1:0] d2, logic [XLEN-1:0] cd,
                            output instr_t got, output logic valid);
    instr_t exp;
    rm_t    exp_rm;
    logic   cw, ff;
    valid = 1'b0;
    got = '0;
    if (op == '0) return;
    if (q.size() == 0) begin
      report_fault(0, "an instruction issued that decode never sent or a redirect dropped");
      return;
    end
    exp = q.pop_front();
    got = exp;
    valid = 1'b1;
    exp_rm = (fs == FS_OFF) ? rm_t'(0) : (exp.rm == RM_DYN) ? frm : exp.rm;
    check_op(3, (fs == FS_OFF) ? (exp.op & ~OP_FP_MASK) : exp.op, op);
    check_rm(3, exp_rm, rm);
    check_addr(0, exp.r1, r1);
    check_addr(0, exp.r2, r2);
    check_addr(0, exp.r3, r3);
    check_addr(0, exp.wa, wa);
    check_caddr(0, exp.ca, ca);
    if (op[OP_RDEN1]) check_data(4, rf_read(r1), d1);
    if (op[OP_RDEN2]) check_data(4, rf_read(r2), d2);
    if (op[OP_CRDEN]) check_data(4, fp_csr_ready ? fp_csr_cdata : csr_cdata, cd);
    checks[2]++;
    cw = 1'b0;
    ff = 1'b0;
    for (int a = 0; a < 2; a++) begin
      for (int s = 0; s < 2; s++) begin
        cw |= h_op[a][s][OP_CWREN];
        ff |= h_op[a][s][OP_FPUF];
        if (a == 0 && uses_load(h_op[0][s], h_wa[0][s], op, r1, r2, r3))
          report_fault(2, "a slot read a register loaded in the previous issue cycle");
      end
    end
    if (op[OP_CRDEN] && cw) report_fault(2, "a CSR read issued behind a CSR write");
    if (op[OP_CRDEN] && (ca == CSR_FFLAGS || ca == CSR_FCSR) && ff)
      report_fault(2, "an fflags or fcsr read issued behind a flag-writing FP op");
  endtask

  // fp and csr read requests of the cycle before the issue edge.
  task automatic check_requests();
    op_t       m0, m1;
    reg_addr_t a0 [3];
    reg_addr_t a1 [3];
    m0 = (fs == FS_OFF) ? (g0.op & ~OP_FP_MASK) : g0.op;
    m1 = (fs == FS_OFF) ? (g1.op & ~OP_FP_MASK) : g1.op;
    a0 = '{g0.r1, g0.r2, g0.r3};
    a1 = '{g1.r1, g1.r2, g1.r3};
    check_flag(5, m0[OP_CRDEN] || m1[OP_CRDEN], req_crden);
    if (m0[OP_CRDEN] || m1[OP_CRDEN])
      check_caddr(5, m0[OP_CRDEN] ? g0.ca : g1.ca, req_craddr);
    for (int k = 0; k < 3; k++) begin
      check_flag(5, m0[OP_FRDEN1 + k] || m1[OP_FRDEN1 + k], req_frden[k]);
      if (m0[OP_FRDEN1 + k] || m1[OP_FRDEN1 + k])
        check_addr(5, m0[OP_FRDEN1 + k] ? a0[k] : a1[k], req_fraddr[k]);
    end
  endtask

  task automatic observe_edge();
    if (redirect) begin
      q.delete(); // younger work is gone.
      h_op = '{default: '0};
      check_op(0, '0, iss0_op);
      check_op(0, '0, iss1_op);
      check_flag(0, 1'b0, halt);
    end else if (!hold) begin
      check_slot(iss0_op, iss0_raddr1, iss0_raddr2, iss0_raddr3, iss0_waddr, iss0_caddr,
                 iss0_rm, iss0_rdata1, iss0_rdata2, iss0_cdata, g0, v0);
      check_slot(iss1_op, iss1_raddr1, iss1_raddr2, iss1_raddr3, iss1_waddr, iss1_caddr,
                 iss1_rm, iss1_rdata1, iss1_rdata2, iss1_cdata, g1, v1);
      if (v1) begin
        checks[1]++;
        if (!v0) report_fault(1, "slot1 issued without slot0");
        else if (!pair_ok(g0, g1)) report_fault(1, "slots issued together break the rules");
      end
      if (v0) check_requests();
      h_op[1] = h_op[0];
      h_wa[1] = h_wa[0];
      h_op[0] = '{iss0_op, iss1_op};
      h_wa[0] = '{iss0_waddr, iss1_waddr};
    end
    if (acc) begin
      pending = 1'b0;
      if (!redirect) begin
        q.push_back(pend0);
        if (pend1.op != '0) q.push_back(pend1);
      end
    end
    if (wb0_en) regs_model[wb0_addr] = wb0_data;
    if (wb1_en) regs_model[wb1_addr] = wb1_data; // later write wins.
  endtask

  task automatic drive_random();
    logic busy;
    busy = sent < NPAIRS || pending;
    hold = busy && ($urandom % 5 == 0);
    redirect = busy && ($urandom % 32 == 0);
    fs = ($urandom % 4 == 0) ? FS_OFF : fs_t'(1 + $urandom % 3);
    frm = rm_t'($urandom);
    csr_cdata = $urandom;
    fp_csr_cdata = $urandom;
    fp_csr_ready = $urandom % 2;
    wb0_en = $urandom % 2;
    wb1_en = $urandom % 2;
    wb0_addr = reg_addr_t'(1 + $urandom % 31);
    wb1_addr = reg_addr_t'(1 + $urandom % 31);
    wb0_data = $urandom;
    wb1_data = $urandom;
    if (!pending && sent < NPAIRS && $urandom % 4 != 0) begin
      pend0 = random_instr();
      pend1 = random_instr();
      if ($urandom % 4 == 0) pend1.op = '0;
      pending = 1'b1;
      sent++;
    end
    dec_valid = pending;
    {dec0_op, dec0_raddr1, dec0_raddr2, dec0_raddr3, dec0_waddr, dec0_caddr, dec0_rm} = pend0;
    {dec1_op, dec1_raddr1, dec1_raddr2, dec1_raddr3, dec1_waddr, dec1_caddr, dec1_rm} = pend1;
  endtask

  initial begin
    int total;
    void'($urandom(32'hd6b));
    clock = 1'b0;
    reset = 1'b0;
    {dec_valid, hold, redirect, fp_csr_ready, wb0_en, wb1_en} = '0;
    {pend0, pend1, fs, frm, csr_cdata, fp_csr_cdata} = '0;
    {wb0_addr, wb1_addr, wb0_data, wb1_data} = '0;
    {dec0_op, dec0_raddr1, dec0_raddr2, dec0_raddr3, dec0_waddr, dec0_caddr, dec0_rm} = '0;
    {dec1_op, dec1_raddr1, dec1_raddr2, dec1_raddr3, dec1_waddr, dec1_caddr, dec1_rm} = '0;
    h_op = '{default: '0};
    h_wa = '{default: '0};
    regs_model = '{default: '0};
    req_crden = 1'b0;
    req_frden = '0;
    req_craddr = '0;
    req_fraddr = '{default: '0};
    pending = 1'b0;
    acc = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clock);
      if (wb0_en) regs_model[wb0_addr] = wb0_data;
      if (wb1_en) regs_model[wb1_addr] = wb1_data;
      wb0_en = 1'b1; // fill the whole register file.
      wb0_addr = reg_addr_t'(2 * i + 1);
      wb0_data = $urandom;
      wb1_en = i < 15;
      wb1_addr = reg_addr_t'(2 * i + 2);
      wb1_data = $urandom;
    end
    check_op(0, '0, iss0_op);
    check_op(0, '0, iss1_op);
    check_flag(0, 1'b0, halt);
    reset = 1'b1;
    while (sent < NPAIRS || pending || q.size() != 0) begin
      @(negedge clock);
      observe_edge();
      drive_random();
      #1;
      acc = dec_valid && !halt;
      req_crden = crden;
      req_craddr = craddr;
      req_frden = {frden3, frden2, frden1};
      req_fraddr = '{fraddr1, fraddr2, fraddr3};
    end
    total = 0;
    for (int t = 0; t < 6; t++) begin
      $display("%s: %0d checks, %0d errors", names[t], checks[t], errors[t]);
      total += errors[t];
    end
    $display("pairs sent %0d, errors %0d, cycles %0d", sent, total, cycles);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
